// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -O2
TOP       := tb_walksat_flip
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) source/sat_cfg.svh

.PHONY: all run check clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(SIM_LOG) 2>&1
	cat $(SIM_LOG)
	grep -q "Verification passed" $(SIM_LOG)

check:
	grep -q "Verification passed" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== source/break_evaluator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sat_cfg.svh"

module break_evaluator
    import sat_pkg::*;
(
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        hit_valid_i,
    input  wire lit_idx_t              hit_idx_i,
    input  wire lit_u                  hit_lit_i,
    input  wire occ_entry_t            hit_entry_i,
    output var_addr_t [2*`WS_MC-1:0]   var_rd_addr_o,
    input  wire [2*`WS_MC-1:0]         var_rd_val_i,
    brk_if.src                         brk
);

    // per slot, both other literals currently false
    logic [`WS_MC-1:0] slot_brk;
    brk_cnt_t          cnt;

    // two reads per slot, slot s uses 2s and 2s+1
    always_comb begin
        for (int s = 0; s < `WS_MC; s++) begin
            for (int k = 0; k < 2; k++) begin
                var_rd_addr_o[2*s+k] = hit_entry_i[s].other[k].f.var_addr;
            end
        end
    end

    // literal is false when value equals its neg bit
    always_comb begin
        cnt = '0;
        for (int s = 0; s < `WS_MC; s++) begin
            slot_brk[s] = hit_entry_i[s].valid
                && (var_rd_val_i[2*s] == hit_entry_i[s].other[0].f.neg)
                && (var_rd_val_i[2*s+1] == hit_entry_i[s].other[1].f.neg);
            cnt = cnt + brk_cnt_t'(slot_brk[s]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            brk.valid <= 1'b0;
        end else begin
            brk.valid <= hit_valid_i;
        end
    end

    // result payload rides along with valid
    always_ff @(posedge clk_i) begin
        brk.idx <= hit_idx_i;
        brk.lit <= hit_lit_i;
        brk.cnt <= cnt;
    end

endmodule

`default_nettype wire

// ==== source/clause_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sat_cfg.svh"

module clause_decoder
    import sat_pkg::*;
(
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              req_i,
    input  wire clause_t     clause_i,
    input  wire              occ_wr_en_i,
    input  wire lit_u        occ_wr_addr_i,
    input  wire occ_entry_t  occ_wr_data_i,
    output logic             hit_valid_o,
    output lit_idx_t         hit_idx_o,
    output lit_u             hit_lit_o,
    output occ_entry_t       hit_entry_o
);

    // occurrence table, one entry per literal
    occ_entry_t occ_mem [0:(1 << `WS_LIT_W) - 1];

    // latched clause and sequencer state
    clause_t  clause_q;
    lit_idx_t step_q;
    logic     run_q;
    // set until req drops, blocks a second start
    logic     hold_q;
    logic     start;

    // lookup stage, one literal per cycle
    logic     lk_vld_q;
    lit_idx_t lk_idx_q;
    lit_u     lk_lit_q;
    lit_u     lk_addr;

    assign start = req_i && !run_q && !hold_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_q    <= 1'b0;
            hold_q   <= 1'b0;
            step_q   <= '0;
            lk_vld_q <= 1'b0;
        end else if (start) begin
            // literal 0 is taken straight from the port
            run_q    <= 1'b1;
            hold_q   <= 1'b1;
            step_q   <= lit_idx_t'(1);
            lk_vld_q <= 1'b1;
        end else if (run_q) begin
            lk_vld_q <= 1'b1;
            if (step_q == lit_idx_t'(`WS_NSAT - 1)) begin
                run_q <= 1'b0;
            end else begin
                step_q <= step_q + lit_idx_t'(1);
            end
        end else begin
            lk_vld_q <= 1'b0;
            // four-phase, rearm only once req is back low
            if (!req_i) begin
                hold_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            clause_q <= clause_i;
            lk_idx_q <= '0;
            lk_lit_q <= clause_i[0];
        end else if (run_q) begin
            lk_idx_q <= step_q;
            lk_lit_q <= clause_q[step_q];
        end
    end

    // complement literal indexes the table
    always_comb begin
        lk_addr       = lk_lit_q;
        lk_addr.f.neg = ~lk_lit_q.f.neg;
    end

    // table write port and registered read
    always_ff @(posedge clk_i) begin
        if (occ_wr_en_i) begin
            occ_mem[occ_wr_addr_i.raw] <= occ_wr_data_i;
        end
        hit_entry_o <= occ_mem[lk_addr.raw];
        hit_idx_o   <= lk_idx_q;
        hit_lit_o   <= lk_lit_q;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hit_valid_o <= 1'b0;
        end else begin
            hit_valid_o <= lk_vld_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/flip_selector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sat_cfg.svh"

module flip_selector
    import sat_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire        req_i,
    brk_if.dst         brk,
    output var_addr_t  sel_addr_o,
    input  wire        sel_val_i,
    output logic       flip_en_o,
    output var_addr_t  flip_addr_o,
    output logic       flip_val_o,
    output logic       ack_o,
    output var_addr_t  flip_var_o
);

    // results of literals 0 and 1, held until the last arrives
    brk_cnt_t [1:0]          cnt_q;
    lit_u [1:0]              lit_q;
    // full set, last one straight off the bus
    brk_cnt_t [`WS_NSAT-1:0] cnt_all;
    lit_u [`WS_NSAT-1:0]     lit_all;
    logic                    last;

    logic [31:0] prng_q;
    logic [31:0] prng_nxt;
    brk_cnt_t    min_cnt;
    lit_idx_t    min_idx;
    lit_idx_t    rnd_idx;
    lit_idx_t    pick;
    logic        noisy;

    assign last    = brk.valid && (brk.idx == lit_idx_t'(`WS_NSAT - 1));
    assign cnt_all = {brk.cnt, cnt_q};
    assign lit_all = {brk.lit, lit_q};

    // xorshift32, shifts 13 / 17 / 5
    always_comb begin
        prng_nxt = prng_q ^ (prng_q << 13);
        prng_nxt = prng_nxt ^ (prng_nxt >> 17);
        prng_nxt = prng_nxt ^ (prng_nxt << 5);
    end

    always_comb begin
        // strict compare keeps the lowest index on ties
        min_cnt = cnt_all[0];
        min_idx = '0;
        for (int i = 1; i < `WS_NSAT; i++) begin
            if (cnt_all[i] < min_cnt) begin
                min_cnt = cnt_all[i];
                min_idx = lit_idx_t'(i);
            end
        end
        // random index 3 folds back onto literal 0
        rnd_idx = (prng_nxt[9:8] == 2'd3) ? 2'd0 : prng_nxt[9:8];
        noisy   = prng_nxt[7:0] < `WS_NOISE;
        // min index is already the lowest zero when one exists
        if (min_cnt == '0 || !noisy) begin
            pick = min_idx;
        end else begin
            pick = rnd_idx;
        end
    end

    // chosen variable goes to the table read port
    assign sel_addr_o = lit_all[pick].f.var_addr;
    assign flip_var_o = flip_addr_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prng_q    <= `WS_PRNG_SEED;
            ack_o     <= 1'b0;
            flip_en_o <= 1'b0;
        end else begin
            // one write per request
            flip_en_o <= last;
            if (last) begin
                prng_q <= prng_nxt;
                ack_o  <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (brk.valid && !last) begin
            cnt_q[brk.idx[0]] <= brk.cnt;
            lit_q[brk.idx[0]] <= brk.lit;
        end
        // result held while ack is up
        if (last) begin
            flip_addr_o <= sel_addr_o;
            flip_val_o  <= ~sel_val_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/sat_cfg.svh ====
`ifndef SAT_CFG_SVH
`define SAT_CFG_SVH

// literals per clause, 3-SAT
`define WS_NSAT 3
// variable count and its address width
`define WS_NUM_VARS 16
`define WS_VAR_W 4
// literal word is neg bit on top of the variable address
`define WS_LIT_W 5
// clause slots held per occurrence entry
`define WS_MC 4
// break count, wide enough for WS_MC
`define WS_CNT_W 3
// xorshift start state, never zero
`define WS_PRNG_SEED 32'h2545_f491
// noise threshold out of 256
`define WS_NOISE 8'd77

`endif

// ==== source/sat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// per-literal break result, evaluator to selector
// valid is a one-cycle pulse, selector always accepts
interface brk_if
    import sat_pkg::*;
();
    // result strobe
    logic     valid;
    // which literal of the clause
    lit_idx_t idx;
    // the clause literal itself, not its complement
    lit_u     lit;
    // clauses broken by flipping lit's variable
    brk_cnt_t cnt;

    // evaluator side
    modport src (
        output valid,
        output idx,
        output lit,
        output cnt
    );

    // selector side
    modport dst (
        input valid,
        input idx,
        input lit,
        input cnt
    );

endinterface

`default_nettype wire

// ==== source/sat_pkg.sv ====
`default_nettype none

`include "sat_cfg.svh"

package sat_pkg;

    typedef logic [`WS_VAR_W-1:0] var_addr_t;
    typedef logic [`WS_CNT_W-1:0] brk_cnt_t;
    // position of a literal inside its clause
    typedef logic [1:0] lit_idx_t;

    // negation bit is the msb
    typedef struct packed {
        logic      neg;
        var_addr_t var_addr;
    } lit_fields_t;

    // raw view doubles as the occurrence table index
    typedef union packed {
        logic [`WS_LIT_W-1:0] raw;
        lit_fields_t          f;
    } lit_u;

    // literal 0 sits in the low bits
    typedef lit_u [`WS_NSAT-1:0] clause_t;

    // one clause holding the indexing literal, minus that literal
    typedef struct packed {
        lit_u [1:0] other;
        logic       valid;
    } occ_slot_t;

    typedef occ_slot_t [`WS_MC-1:0] occ_entry_t;

endpackage

`default_nettype wire

// ==== source/variable_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sat_cfg.svh"

module variable_table
    import sat_pkg::*;
(
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire                          load_en_i,
    input  wire var_addr_t               load_addr_i,
    input  wire                          load_val_i,
    input  wire                          flip_en_i,
    input  wire var_addr_t               flip_addr_i,
    input  wire                          flip_val_i,
    input  wire var_addr_t [2*`WS_MC-1:0] eval_addr_i,
    output logic [2*`WS_MC-1:0]          eval_val_o,
    input  wire var_addr_t               sel_addr_i,
    output logic                         sel_val_o,
    input  wire var_addr_t               dbg_addr_i,
    output logic                         dbg_val_o
);

    // current assignment, one bit per variable
    logic [`WS_NUM_VARS-1:0] vals_q;

    // flip wins over a load to the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vals_q <= '0;
        end else if (flip_en_i) begin
            vals_q[flip_addr_i] <= flip_val_i;
        end else if (load_en_i) begin
            vals_q[load_addr_i] <= load_val_i;
        end
    end

    // async read ports for the evaluator
    always_comb begin
        for (int i = 0; i < 2*`WS_MC; i++) begin
            eval_val_o[i] = vals_q[eval_addr_i[i]];
        end
    end

    assign sel_val_o = vals_q[sel_addr_i];
    assign dbg_val_o = vals_q[dbg_addr_i];

endmodule

`default_nettype wire

// ==== source/walksat_flip_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sat_cfg.svh"

module walksat_flip_top
    import sat_pkg::*;
(
    input  wire                               clk_i,
    input  wire                               rst_i,
    input  wire                               req_i,
    input  wire [`WS_NSAT*`WS_LIT_W-1:0]      clause_i,
    output wire                               ack_o,
    output wire [`WS_VAR_W-1:0]               flip_var_o,
    output wire                               flip_val_o,
    input  wire                               occ_wr_en_i,
    input  wire [`WS_LIT_W-1:0]               occ_wr_addr_i,
    input  wire [`WS_MC*(2*`WS_LIT_W+1)-1:0]  occ_wr_data_i,
    input  wire                               var_wr_en_i,
    input  wire [`WS_VAR_W-1:0]               var_wr_addr_i,
    input  wire                               var_wr_val_i,
    input  wire [`WS_VAR_W-1:0]               var_rd_addr_i,
    output wire                               var_rd_val_o
);

    // decoder to evaluator lookup result
    wire                          hit_valid;
    wire lit_idx_t                hit_idx;
    wire lit_u                    hit_lit;
    wire occ_entry_t              hit_entry;
    // evaluator reads of the other literals
    wire var_addr_t [2*`WS_MC-1:0] eval_addr;
    wire [2*`WS_MC-1:0]           eval_val;
    // selector read and flip write
    wire var_addr_t               sel_addr;
    wire                          sel_val;
    wire                          flip_en;
    wire var_addr_t               flip_addr;

    brk_if i_brk ();

    clause_decoder i_decoder (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .clause_i      (clause_i),
        .occ_wr_en_i   (occ_wr_en_i),
        .occ_wr_addr_i (occ_wr_addr_i),
        .occ_wr_data_i (occ_wr_data_i),
        .hit_valid_o   (hit_valid),
        .hit_idx_o     (hit_idx),
        .hit_lit_o     (hit_lit),
        .hit_entry_o   (hit_entry)
    );

    break_evaluator i_evaluator (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .hit_valid_i   (hit_valid),
        .hit_idx_i     (hit_idx),
        .hit_lit_i     (hit_lit),
        .hit_entry_i   (hit_entry),
        .var_rd_addr_o (eval_addr),
        .var_rd_val_i  (eval_val),
        .brk           (i_brk.src)
    );

    // host load port shares the table with the flip write
    variable_table i_var_table (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .load_en_i   (var_wr_en_i),
        .load_addr_i (var_wr_addr_i),
        .load_val_i  (var_wr_val_i),
        .flip_en_i   (flip_en),
        .flip_addr_i (flip_addr),
        .flip_val_i  (flip_val_o),
        .eval_addr_i (eval_addr),
        .eval_val_o  (eval_val),
        .sel_addr_i  (sel_addr),
        .sel_val_o   (sel_val),
        .dbg_addr_i  (var_rd_addr_i),
        .dbg_val_o   (var_rd_val_o)
    );

    flip_selector i_selector (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .brk         (i_brk.dst),
        .sel_addr_o  (sel_addr),
        .sel_val_i   (sel_val),
        .flip_en_o   (flip_en),
        .flip_addr_o (flip_addr),
        .flip_val_o  (flip_val_o),
        .ack_o       (ack_o),
        .flip_var_o  (flip_var_o)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/sat_pkg.sv
source/sat_if.sv
source/clause_decoder.sv
source/break_evaluator.sv
source/variable_table.sv
source/flip_selector.sv
source/walksat_flip_top.sv
testbench/tb_walksat_flip.sv

// ==== testbench/tb_walksat_flip.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sat_cfg.svh"

module tb_walksat_flip
    import sat_pkg::*;
();

    localparam int N_RAND = 200;
    localparam int N_ZERO = 50;
    localparam int N_LITS = 1 << `WS_LIT_W;
    localparam int ACK_WAIT = 50;
    // reset, table loads, two readback passes and the zero-test reloads
    localparam int LOAD_CYCLES = 10 + 2 * N_LITS + 6 * `WS_NUM_VARS + 2 * N_ZERO + 100;
    localparam int WATCHDOG_CYCLES = 200 * (N_RAND + N_ZERO) + LOAD_CYCLES;

    logic       clk_i;
    logic       rst_i;
    logic       req_i;
    clause_t    clause_i;
    logic       ack_o;
    var_addr_t  flip_var_o;
    logic       flip_val_o;
    logic       occ_wr_en_i;
    lit_u       occ_wr_addr_i;
    occ_entry_t occ_wr_data_i;
    logic       var_wr_en_i;
    var_addr_t  var_wr_addr_i;
    logic       var_wr_val_i;
    var_addr_t  var_rd_addr_i;
    logic       var_rd_val_o;

    // stimulus source and reference model state
    logic [15:0]             lfsr_q;
    logic [31:0]             prng_m;
    logic [`WS_NUM_VARS-1:0] vars_m;
    occ_entry_t              occ_m [0:N_LITS-1];
    int                      flips_m;
    // ack monitor state
    int                      acks_seen;
    logic                    ack_prev;

    walksat_flip_top i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .clause_i      (clause_i),
        .ack_o         (ack_o),
        .flip_var_o    (flip_var_o),
        .flip_val_o    (flip_val_o),
        .occ_wr_en_i   (occ_wr_en_i),
        .occ_wr_addr_i (occ_wr_addr_i),
        .occ_wr_data_i (occ_wr_data_i),
        .var_wr_en_i   (var_wr_en_i),
        .var_wr_addr_i (var_wr_addr_i),
        .var_wr_val_i  (var_wr_val_i),
        .var_rd_addr_i (var_rd_addr_i),
        .var_rd_val_o  (var_rd_val_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // ack rising edges counted straight off the DUT port
    always @(negedge clk_i) begin
        if (rst_i) begin
            acks_seen = 0;
            ack_prev  = 1'b0;
        end else begin
            if (ack_o === 1'b1 && !ack_prev) begin
                acks_seen++;
            end
            ack_prev = (ack_o === 1'b1);
        end
    end

    // 16-bit galois lfsr, taps 16/14/13/11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic lit_u rand_lit();
        logic [31:0] r;
        r = rand_bits(`WS_LIT_W);
        return r[`WS_LIT_W-1:0];
    endfunction

    function automatic occ_entry_t rand_entry();
        occ_entry_t  e;
        logic [31:0] r;
        for (int s = 0; s < `WS_MC; s++) begin
            e[s].other[0] = rand_lit();
            e[s].other[1] = rand_lit();
            r = rand_bits(2);
            // mostly valid slots, so nonzero counts and noise picks show up
            e[s].valid = r[0] | r[1];
        end
        return e;
    endfunction

    function automatic clause_t rand_clause();
        clause_t c;
        for (int i = 0; i < `WS_NSAT; i++) begin
            c[i] = rand_lit();
        end
        return c;
    endfunction

    // reference xorshift32, 13 left, 17 right, 5 left
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // true when the variable differs from the neg bit
    function automatic logic lit_true(input lit_u l);
        return vars_m[l.f.var_addr] != l.f.neg;
    endfunction

    // clauses in the complement entry left with no true literal
    function automatic brk_cnt_t model_breaks(input lit_u lit);
        lit_u       comp;
        occ_entry_t e;
        brk_cnt_t   c;
        comp = lit;
        comp.f.neg = ~lit.f.neg;
        e = occ_m[comp.raw];
        c = '0;
        for (int s = 0; s < `WS_MC; s++) begin
            if (e[s].valid && !lit_true(e[s].other[0]) && !lit_true(e[s].other[1])) begin
                c = c + brk_cnt_t'(1);
            end
        end
        return c;
    endfunction

    task automatic model_select(input clause_t c, output var_addr_t v, output logic val);
        brk_cnt_t    cnt [0:`WS_NSAT-1];
        logic        has_zero;
        lit_idx_t    zero_at;
        lit_idx_t    pick;
        logic [31:0] r;
        has_zero = 1'b0;
        zero_at  = '0;
        // walk down so the lowest zero is kept
        for (int i = `WS_NSAT - 1; i >= 0; i--) begin
            cnt[i] = model_breaks(c[i]);
            if (cnt[i] == '0) begin
                has_zero = 1'b1;
                zero_at  = lit_idx_t'(i);
            end
        end
        // prng advances once per request, used or not
        prng_m = xorshift(prng_m);
        r = prng_m;
        if (has_zero) begin
            pick = zero_at;
        end else if (r[7:0] < `WS_NOISE) begin
            pick = (r[9:8] == 2'd3) ? 2'd0 : r[9:8];
        end else begin
            pick = '0;
            for (int i = 1; i < `WS_NSAT; i++) begin
                if (cnt[i] < cnt[pick]) begin
                    pick = lit_idx_t'(i);
                end
            end
        end
        v = c[pick].f.var_addr;
        val = ~vars_m[v];
        vars_m[v] = val;
        flips_m++;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_var(input string name, input var_addr_t exp, input var_addr_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input brk_cnt_t exp, input brk_cnt_t act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic load_occ(input lit_u addr, input occ_entry_t e);
        @(negedge clk_i);
        occ_wr_en_i   = 1'b1;
        occ_wr_addr_i = addr;
        occ_wr_data_i = e;
        @(negedge clk_i);
        occ_wr_en_i = 1'b0;
        occ_m[addr.raw] = e;
    endtask

    task automatic load_var(input var_addr_t a, input logic v);
        @(negedge clk_i);
        var_wr_en_i   = 1'b1;
        var_wr_addr_i = a;
        var_wr_val_i  = v;
        @(negedge clk_i);
        var_wr_en_i = 1'b0;
        vars_m[a] = v;
    endtask

    // readback is combinational, sampled one falling edge later
    task automatic read_var(input var_addr_t a, output logic v);
        @(negedge clk_i);
        var_rd_addr_i = a;
        @(negedge clk_i);
        v = var_rd_val_o;
    endtask

    task automatic check_vars(input string name);
        logic rd;
        for (int i = 0; i < `WS_NUM_VARS; i++) begin
            read_var(var_addr_t'(i), rd);
            check_bit($sformatf("%s var %0d", name, i), vars_m[i], rd);
        end
    endtask

    // one four-phase handshake against the model
    task automatic run_clause(input string name, input clause_t c);
        var_addr_t exp_var;
        logic      exp_val;
        logic      rd;
        int        waited;
        model_select(c, exp_var, exp_val);
        @(negedge clk_i);
        clause_i = c;
        req_i    = 1'b1;
        waited   = 0;
        while (ack_o !== 1'b1) begin
            @(negedge clk_i);
            waited++;
            if (waited > ACK_WAIT) begin
                abort_run($sformatf("%s: no ack within %0d cycles of req", name, ACK_WAIT));
            end
        end
        check_var({name, " flip_var"}, exp_var, flip_var_o);
        check_bit({name, " flip_val"}, exp_val, flip_val_o);
        // ack must drop one cycle after req does
        req_i = 1'b0;
        @(negedge clk_i);
        check_bit({name, " ack fall"}, 1'b0, ack_o);
        read_var(exp_var, rd);
        check_bit({name, " readback"}, exp_val, rd);
        check_count("flip total", brk_cnt_t'(flips_m), brk_cnt_t'(acks_seen));
    endtask

    initial begin
        clause_t     c;
        occ_entry_t  e;
        lit_u        comp;
        lit_idx_t    z;
        logic [31:0] r;
        rst_i         = 1'b1;
        req_i         = 1'b0;
        clause_i      = '0;
        occ_wr_en_i   = 1'b0;
        occ_wr_addr_i = '0;
        occ_wr_data_i = '0;
        var_wr_en_i   = 1'b0;
        var_wr_addr_i = '0;
        var_wr_val_i  = 1'b0;
        var_rd_addr_i = '0;
        lfsr_q        = 16'd98;
        prng_m        = `WS_PRNG_SEED;
        vars_m        = '0;
        flips_m       = 0;
        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;

        // table clears on reset, no ack pending
        check_bit("reset ack", 1'b0, ack_o);
        check_vars("reset readback");

        for (int a = 0; a < N_LITS; a++) begin
            comp.raw = a[`WS_LIT_W-1:0];
            load_occ(comp, rand_entry());
        end
        for (int v = 0; v < `WS_NUM_VARS; v++) begin
            r = rand_bits(1);
            load_var(var_addr_t'(v), r[0]);
        end
        check_vars("load readback");

        for (int n = 0; n < N_RAND; n++) begin
            c = rand_clause();
            run_clause($sformatf("random clause %0d", n), c);
        end

        // empty complement entry forces a zero break on literal z
        for (int n = 0; n < N_ZERO; n++) begin
            c = rand_clause();
            r = rand_bits(2);
            z = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];
            comp = c[z];
            comp.f.neg = ~comp.f.neg;
            e = rand_entry();
            for (int s = 0; s < `WS_MC; s++) begin
                e[s].valid = 1'b0;
            end
            load_occ(comp, e);
            run_clause($sformatf("zero break clause %0d", n), c);
        end

        $display("Verification passed");
        $finish;
    end

    // hard limit on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Verification failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire
